/* dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address width
`define DC_ADDR_W 32
// core data word
`define DC_XLEN 64

// set geometry
`define DC_SETS 64
`define DC_INDEX_W 6
`define DC_OFFSET_W 5

// address bits left above index and offset
`define DC_TAG_W 21

// words per line and refill beats per miss
`define DC_BEATS 4

`endif

/* dcachePkg.sv */
`include "dcache_settings.svh"
`default_nettype none

package dcachePkg;

  typedef logic [`DC_ADDR_W-1:0] addrT;
  typedef logic [`DC_XLEN-1:0] wordT;
  typedef logic [`DC_BEATS*`DC_XLEN-1:0] lineT;
  typedef logic [`DC_TAG_W-1:0] tagT;
  typedef logic [`DC_INDEX_W-1:0] indexT;

  // doubleword slot inside a line
  typedef logic [$clog2(`DC_BEATS)-1:0] beatT;

  // one enable per byte lane
  typedef logic [`DC_XLEN/8-1:0] byteMaskT;

  typedef logic wayT;

  typedef enum logic [2:0] {
    Idle,
    Compare,
    WriteBack,
    MissReq,
    Refill,
    Fill
  } ctrlStateT;

endpackage

`default_nettype wire

/* dcacheTagStore.sv */
`include "dcache_settings.svh"
`default_nettype none

module dcacheTagStore (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire dcachePkg::indexT index_i,
  input  wire dcachePkg::tagT   tag_i,
  input  wire dcachePkg::wayT   victimWay_i,
  input  wire                 fill_i,
  input  wire                 markDirty_i,
  output logic                hit_o,
  output dcachePkg::wayT      hitWay_o,
  output logic                victimDirty_o,
  output dcachePkg::tagT      victimTag_o
);
  import dcachePkg::*;

  logic [1:0][`DC_SETS-1:0] validQ;
  logic [1:0][`DC_SETS-1:0] dirtyQ;
  tagT                      tagQ [2][`DC_SETS];
  logic [1:0]               wayHit;

  // compare both ways in parallel
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = validQ[w][index_i] && (tagQ[w][index_i] == tag_i);
    end
  end

  assign hit_o = |wayHit;
  assign hitWay_o = wayHit[1];

  // an invalid victim never needs a write-back
  assign victimDirty_o = validQ[victimWay_i][index_i] && dirtyQ[victimWay_i][index_i];
  assign victimTag_o = tagQ[victimWay_i][index_i];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      dirtyQ <= '0;
    end else if (fill_i) begin
      // fresh line from memory is clean
      validQ[victimWay_i][index_i] <= 1'b1;
      dirtyQ[victimWay_i][index_i] <= 1'b0;
    end else if (markDirty_i) begin
      dirtyQ[hitWay_o][index_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill_i) begin
      tagQ[victimWay_i][index_i] <= tag_i;
    end
  end

endmodule

`default_nettype wire

/* dcacheDataStore.sv */
`include "dcache_settings.svh"
`default_nettype none

module dcacheDataStore (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire dcachePkg::indexT     index_i,
  input  wire dcachePkg::beatT      beat_i,
  input  wire dcachePkg::wayT       hitWay_i,
  input  wire dcachePkg::wayT       victimWay_i,
  input  wire                     storeEn_i,
  input  wire dcachePkg::wordT      storeData_i,
  input  wire dcachePkg::byteMaskT  storeMask_i,
  input  wire                     fill_i,
  input  wire dcachePkg::lineT      fillLine_i,
  output dcachePkg::wordT         rdWord_o,
  output dcachePkg::lineT         victimLine_o
);
  import dcachePkg::*;

  lineT lineQ [2][`DC_SETS];
  lineT hitLine;
  wordT oldWord;
  wordT mergedWord;

  // hit way word for loads and the store merge
  always_comb begin
    hitLine = lineQ[hitWay_i][index_i];
    oldWord = hitLine[beat_i*`DC_XLEN +: `DC_XLEN];
    for (int b = 0; b < `DC_XLEN/8; b++) begin
      mergedWord[b*8 +: 8] = storeMask_i[b] ? storeData_i[b*8 +: 8] : oldWord[b*8 +: 8];
    end
  end

  assign rdWord_o = oldWord;
  assign victimLine_o = lineQ[victimWay_i][index_i];

  // refill writes the victim way and stores merge into the hit way
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int w = 0; w < 2; w++) begin
        for (int s = 0; s < `DC_SETS; s++) begin
          lineQ[w][s] <= '0;
        end
      end
    end else if (fill_i) begin
      lineQ[victimWay_i][index_i] <= fillLine_i;
    end else if (storeEn_i) begin
      lineQ[hitWay_i][index_i][beat_i*`DC_XLEN +: `DC_XLEN] <= mergedWord;
    end
  end

endmodule

`default_nettype wire

/* dcacheRefillBuf.sv */
`include "dcache_settings.svh"
`default_nettype none

module dcacheRefillBuf (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 start_i,
  input  wire                 beatValid_i,
  input  wire dcachePkg::wordT  beatData_i,
  output dcachePkg::lineT     line_o
);
  import dcachePkg::*;

  beatT beatCnt;
  lineT lineQ;

  // lowest word arrives first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (start_i) begin
      beatCnt <= '0;
    end else if (beatValid_i) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (beatValid_i) begin
      lineQ[beatCnt*`DC_XLEN +: `DC_XLEN] <= beatData_i;
    end
  end

  assign line_o = lineQ;

endmodule

`default_nettype wire

/* dcacheCtrl.sv */
`include "dcache_settings.svh"
`default_nettype none

module dcacheCtrl (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     req_valid_i,
  input  wire                     req_we_i,
  input  wire dcachePkg::addrT      req_addr_i,
  input  wire dcachePkg::wordT      req_wdata_i,
  input  wire dcachePkg::byteMaskT  req_wmask_i,
  input  wire                     hit_i,
  input  wire dcachePkg::wayT       hitWay_i,
  input  wire                     victimDirty_i,
  input  wire dcachePkg::tagT       victimTag_i,
  input  wire                     rd_ready_i,
  input  wire                     wr_ready_i,
  input  wire                     mem_rlast_i,
  output logic                    req_ready_o,
  output logic                    rsp_valid_o,
  output dcachePkg::indexT        lookupIndex_o,
  output dcachePkg::tagT          lookupTag_o,
  output dcachePkg::beatT         lookupBeat_o,
  output logic                    storeEn_o,
  output dcachePkg::wordT         storeData_o,
  output dcachePkg::byteMaskT     storeMask_o,
  output logic                    fill_o,
  output dcachePkg::wayT          victimWay_o,
  output logic                    refillStart_o,
  output logic                    rd_valid_o,
  output dcachePkg::addrT         rd_addr_o,
  output logic                    wr_valid_o,
  output dcachePkg::addrT         wr_addr_o
);
  import dcachePkg::*;

  ctrlStateT stateQ;
  ctrlStateT stateD;
  addrT      addrQ;
  logic      weQ;
  wordT      wdataQ;
  byteMaskT  wmaskQ;
  wayT       toggleQ;
  logic      refillDoneQ;
  logic      accept;
  tagT       reqTag;
  indexT     reqIndex;

  assign reqTag = addrQ[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign reqIndex = addrQ[`DC_OFFSET_W +: `DC_INDEX_W];

  // new request only when idle or when the current one hits
  assign req_ready_o = (stateQ == Idle) || ((stateQ == Compare) && hit_i);
  assign accept = req_valid_i && req_ready_o;
  assign rsp_valid_o = (stateQ == Compare) && hit_i;

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      Idle: begin
        if (accept) stateD = Compare;
      end
      Compare: begin
        if (!hit_i) begin
          stateD = victimDirty_i ? WriteBack : MissReq;
        end else if (!accept) begin
          stateD = Idle;
        end
      end
      WriteBack: begin
        if (wr_ready_i) stateD = MissReq;
      end
      MissReq: begin
        if (rd_ready_i) stateD = Refill;
      end
      Refill: begin
        if (mem_rlast_i) stateD = Fill;
      end
      Fill: begin
        stateD = Compare;
      end
      default: begin
        stateD = Idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= Idle;
      weQ <= 1'b0;
      toggleQ <= 1'b0;
      refillDoneQ <= 1'b0;
    end else begin
      stateQ <= stateD;
      if (accept) weQ <= req_we_i;
      if (stateQ == Fill) begin
        refillDoneQ <= 1'b1;
      end else if (stateQ == Compare) begin
        refillDoneQ <= 1'b0;
      end
      // repeat compare hits the refilled way, so move past it
      if ((stateQ == Compare) && refillDoneQ && hit_i) begin
        toggleQ <= ~hitWay_i;
      end
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (accept) begin
      addrQ <= req_addr_i;
      wdataQ <= req_wdata_i;
      wmaskQ <= req_wmask_i;
    end
  end

  assign lookupIndex_o = reqIndex;
  assign lookupTag_o = reqTag;
  assign lookupBeat_o = addrQ[3 +: $bits(beatT)];

  assign storeEn_o = (stateQ == Compare) && hit_i && weQ;
  assign storeData_o = wdataQ;
  assign storeMask_o = wmaskQ;

  assign victimWay_o = toggleQ;
  assign fill_o = (stateQ == Fill);
  assign refillStart_o = (stateQ == MissReq) && rd_ready_i;

  // line-aligned memory addresses
  assign rd_valid_o = (stateQ == MissReq);
  assign rd_addr_o = {reqTag, reqIndex, {`DC_OFFSET_W{1'b0}}};
  assign wr_valid_o = (stateQ == WriteBack);
  assign wr_addr_o = {victimTag_i, reqIndex, {`DC_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

/* dcache2way.sv */
`default_nettype none

module dcache2way (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     req_valid_i,
  input  wire                     req_we_i,
  input  wire dcachePkg::addrT      req_addr_i,
  input  wire dcachePkg::wordT      req_wdata_i,
  input  wire dcachePkg::byteMaskT  req_wmask_i,
  output logic                    req_ready_o,
  output logic                    rsp_valid_o,
  output dcachePkg::wordT         rsp_rdata_o,
  output logic                    rd_valid_o,
  output dcachePkg::addrT         rd_addr_o,
  input  wire                     rd_ready_i,
  input  wire                     mem_rvalid_i,
  input  wire dcachePkg::wordT      mem_rdata_i,
  input  wire                     mem_rlast_i,
  output logic                    wr_valid_o,
  output dcachePkg::addrT         wr_addr_o,
  output dcachePkg::lineT         wr_data_o,
  input  wire                     wr_ready_i
);
  import dcachePkg::*;

  logic     hit;
  wayT      hitWay;
  logic     victimDirty;
  tagT      victimTag;
  indexT    lookupIndex;
  tagT      lookupTag;
  beatT     lookupBeat;
  logic     storeEn;
  wordT     storeData;
  byteMaskT storeMask;
  logic     fill;
  wayT      victimWay;
  logic     refillStart;
  lineT     refillLine;

  dcacheCtrl ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid_i   (req_valid_i),
    .req_we_i      (req_we_i),
    .req_addr_i    (req_addr_i),
    .req_wdata_i   (req_wdata_i),
    .req_wmask_i   (req_wmask_i),
    .hit_i         (hit),
    .hitWay_i      (hitWay),
    .victimDirty_i (victimDirty),
    .victimTag_i   (victimTag),
    .rd_ready_i    (rd_ready_i),
    .wr_ready_i    (wr_ready_i),
    .mem_rlast_i   (mem_rlast_i),
    .req_ready_o   (req_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .lookupIndex_o (lookupIndex),
    .lookupTag_o   (lookupTag),
    .lookupBeat_o  (lookupBeat),
    .storeEn_o     (storeEn),
    .storeData_o   (storeData),
    .storeMask_o   (storeMask),
    .fill_o        (fill),
    .victimWay_o   (victimWay),
    .refillStart_o (refillStart),
    .rd_valid_o    (rd_valid_o),
    .rd_addr_o     (rd_addr_o),
    .wr_valid_o    (wr_valid_o),
    .wr_addr_o     (wr_addr_o)
  );

  dcacheTagStore tagStore_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .index_i       (lookupIndex),
    .tag_i         (lookupTag),
    .victimWay_i   (victimWay),
    .fill_i        (fill),
    .markDirty_i   (storeEn),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  // load word and write-back line straight from the arrays
  dcacheDataStore dataStore_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .index_i      (lookupIndex),
    .beat_i       (lookupBeat),
    .hitWay_i     (hitWay),
    .victimWay_i  (victimWay),
    .storeEn_i    (storeEn),
    .storeData_i  (storeData),
    .storeMask_i  (storeMask),
    .fill_i       (fill),
    .fillLine_i   (refillLine),
    .rdWord_o     (rsp_rdata_o),
    .victimLine_o (wr_data_o)
  );

  dcacheRefillBuf refillBuf_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (refillStart),
    .beatValid_i (mem_rvalid_i),
    .beatData_i  (mem_rdata_i),
    .line_o      (refillLine)
  );

endmodule

`default_nettype wire

/* tbDcacheMem.sv */
`include "dcache_settings.svh"
`default_nettype none

module tbDcacheMem (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire [7:0]             maxDelay_i,
  input  wire                   rd_valid_i,
  input  wire dcachePkg::addrT  rd_addr_i,
  output logic                  rd_ready_o,
  output logic                  mem_rvalid_o,
  output dcachePkg::wordT       mem_rdata_o,
  output logic                  mem_rlast_o,
  input  wire                   wr_valid_i,
  input  wire dcachePkg::addrT  wr_addr_i,
  input  wire dcachePkg::lineT  wr_data_i,
  output logic                  wr_ready_o
);
  import dcachePkg::*;

  // sparse image keyed by doubleword address
  wordT image [addrT];

  // initial word built from line address and word position
  function automatic wordT initWord(addrT lineAddr, int k);
    addrT lowHalf;
    lowHalf = lineAddr + addrT'(k) * 32'h0101_0101;
    return {lineAddr ^ 32'h9e37_79b9, lowHalf};
  endfunction

  function automatic wordT peekWord(addrT addr);
    addrT wordAddr;
    wordAddr = {addr[`DC_ADDR_W-1:3], 3'b000};
    if (image.exists(wordAddr)) begin
      return image[wordAddr];
    end
    return initWord({addr[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}}, int'(addr[4:3]));
  endfunction

  task automatic stall();
    int cycles;
    cycles = $urandom_range(maxDelay_i, maxDelay_i >> 1);
    repeat (cycles) @(negedge clk);
  endtask

  initial begin : serve
    addrT lineAddr;
    rd_ready_o = 1'b0;
    mem_rvalid_o = 1'b0;
    mem_rdata_o = '0;
    mem_rlast_o = 1'b0;
    wr_ready_o = 1'b0;
    forever begin
      @(negedge clk);
      if (rst_n && wr_valid_i) begin
        stall();
        wr_ready_o = 1'b1;
        // line is kept in the cycle it is taken
        for (int k = 0; k < `DC_BEATS; k++) begin
          image[wr_addr_i + addrT'(k * 8)] = wr_data_i[k*`DC_XLEN +: `DC_XLEN];
        end
        @(negedge clk);
        wr_ready_o = 1'b0;
      end else if (rst_n && rd_valid_i) begin
        stall();
        rd_ready_o = 1'b1;
        lineAddr = rd_addr_i;
        @(negedge clk);
        rd_ready_o = 1'b0;
        stall();
        // lowest word first, last flag on the final beat
        for (int k = 0; k < `DC_BEATS; k++) begin
          mem_rvalid_o = 1'b1;
          mem_rdata_o = peekWord(lineAddr + addrT'(k * 8));
          mem_rlast_o = (k == `DC_BEATS - 1);
          @(negedge clk);
        end
        mem_rvalid_o = 1'b0;
        mem_rlast_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_dcache2way.sv */
`include "dcache_settings.svh"
`default_nettype none

module tb_dcache2way;
  import dcachePkg::*;

  localparam int WaitLimit = 400;

  logic     clk;
  logic     rst_n;
  logic     reqValid;
  logic     reqWe;
  addrT     reqAddr;
  wordT     reqWdata;
  byteMaskT reqWmask;
  logic     reqReady;
  logic     rspValid;
  wordT     rspRdata;
  logic     rdValid;
  addrT     rdAddr;
  logic     rdReady;
  logic     memRvalid;
  wordT     memRdata;
  logic     memRlast;
  logic     wrValid;
  addrT     wrAddr;
  lineT     wrData;
  logic     wrReady;
  logic [7:0] memDelay;

  // expected cache contents and replacement toggle
  tagT  shTag [2][`DC_SETS];
  logic shValid [2][`DC_SETS];
  logic shDirty [2][`DC_SETS];
  wayT  toggle;
  wordT written [addrT];

  // what the last request saw on the memory side
  logic rdTaken = 1'b0;
  logic wrTaken = 1'b0;
  logic sawRd;
  logic sawWr;
  logic wrFirst;
  addrT seenRdAddr;
  addrT seenWrAddr;
  lineT seenWrData;
  wordT rspData;
  int   rspCycles;

  dcache2way dcache2way_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (reqValid),
    .req_we_i     (reqWe),
    .req_addr_i   (reqAddr),
    .req_wdata_i  (reqWdata),
    .req_wmask_i  (reqWmask),
    .req_ready_o  (reqReady),
    .rsp_valid_o  (rspValid),
    .rsp_rdata_o  (rspRdata),
    .rd_valid_o   (rdValid),
    .rd_addr_o    (rdAddr),
    .rd_ready_i   (rdReady),
    .mem_rvalid_i (memRvalid),
    .mem_rdata_i  (memRdata),
    .mem_rlast_i  (memRlast),
    .wr_valid_o   (wrValid),
    .wr_addr_o    (wrAddr),
    .wr_data_o    (wrData),
    .wr_ready_i   (wrReady)
  );

  tbDcacheMem memModel (
    .clk          (clk),
    .rst_n        (rst_n),
    .maxDelay_i   (memDelay),
    .rd_valid_i   (rdValid),
    .rd_addr_i    (rdAddr),
    .rd_ready_o   (rdReady),
    .mem_rvalid_o (memRvalid),
    .mem_rdata_o  (memRdata),
    .mem_rlast_o  (memRlast),
    .wr_valid_i   (wrValid),
    .wr_addr_i    (wrAddr),
    .wr_data_i    (wrData),
    .wr_ready_o   (wrReady)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // handshakes as the DUT sees them at the rising edge
  always @(posedge clk) begin
    rdTaken <= rdValid && rdReady;
    wrTaken <= wrValid && wrReady;
  end

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic reportMismatch(input string name, input lineT got, input lineT exp);
    reportFailure($sformatf("Error: time %0t signal %s got %0h expected %0h",
                            $time, name, got, exp));
  endtask

  function automatic addrT composeAddr(tagT tag, indexT idx, beatT beat);
    return {tag, idx, beat, 3'b000};
  endfunction

  function automatic wordT mergeBytes(wordT oldW, wordT newW, byteMaskT mask);
    wordT res;
    for (int b = 0; b < `DC_XLEN / 8; b++) begin
      res[b*8 +: 8] = mask[b] ? newW[b*8 +: 8] : oldW[b*8 +: 8];
    end
    return res;
  endfunction

  // stored words win over the memory image
  function automatic wordT expectedWord(addrT a);
    addrT wa;
    wa = {a[`DC_ADDR_W-1:3], 3'b000};
    if (written.exists(wa)) begin
      return written[wa];
    end
    return memModel.peekWord(a);
  endfunction

  task automatic checkIdleOutputs();
    assert (reqReady === 1'b1) else reportMismatch("req_ready_o", reqReady, 1);
    assert (rspValid === 1'b0) else reportMismatch("rsp_valid_o", rspValid, 0);
    assert (rdValid === 1'b0) else reportMismatch("rd_valid_o", rdValid, 0);
    assert (wrValid === 1'b0) else reportMismatch("wr_valid_o", wrValid, 0);
  endtask

  // memory-side valids must hold with stable payload until taken
  task automatic waitForResponse();
    int   cycles;
    logic prevRd;
    logic prevWr;
    addrT prevRdAddr;
    addrT prevWrAddr;
    lineT prevWrData;
    cycles = 0;
    prevRd = 1'b0;
    prevWr = 1'b0;
    prevRdAddr = '0;
    prevWrAddr = '0;
    prevWrData = '0;
    sawRd = 1'b0;
    sawWr = 1'b0;
    wrFirst = 1'b0;
    do begin
      @(negedge clk);
      reqValid = 1'b0;
      cycles++;
      if (cycles > WaitLimit) begin
        reportFailure("timeout while waiting for rsp_valid_o");
      end
      if (prevRd && !rdTaken) begin
        assert (rdValid) else reportFailure("rd_valid_o dropped before rd_ready_i");
        assert (rdAddr == prevRdAddr) else reportMismatch("rd_addr_o", rdAddr, prevRdAddr);
      end
      if (prevWr && !wrTaken) begin
        assert (wrValid) else reportFailure("wr_valid_o dropped before wr_ready_i");
        assert (wrAddr == prevWrAddr) else reportMismatch("wr_addr_o", wrAddr, prevWrAddr);
        assert (wrData == prevWrData) else reportMismatch("wr_data_o", wrData, prevWrData);
      end
      if (rdValid && !sawRd) begin
        sawRd = 1'b1;
        seenRdAddr = rdAddr;
        wrFirst = sawWr;
      end
      if (wrValid && !sawWr) begin
        sawWr = 1'b1;
        seenWrAddr = wrAddr;
        seenWrData = wrData;
      end
      prevRd = rdValid;
      prevRdAddr = rdAddr;
      prevWr = wrValid;
      prevWrAddr = wrAddr;
      prevWrData = wrData;
      if (!rspValid) begin
        assert (!reqReady) else reportFailure("req_ready_o rose while a miss was pending");
      end
    end while (!rspValid);
    rspCycles = cycles;
    rspData = rspRdata;
  endtask

  // one request with hit, victim and write-back predicted from the expected contents
  task automatic issueAccess(input logic we, input addrT addr, input wordT wdata,
                             input byteMaskT mask);
    tagT   tag;
    indexT idx;
    logic  hitPred;
    wayT   way;
    wayT   victim;
    logic  wbPred;
    addrT  wbAddr;
    lineT  wbLine;
    wordT  expData;
    int    waited;
    tag = addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    idx = addr[`DC_OFFSET_W +: `DC_INDEX_W];
    hitPred = 1'b0;
    way = 1'b0;
    for (int w = 0; w < 2; w++) begin
      if (shValid[w][idx] && shTag[w][idx] == tag) begin
        hitPred = 1'b1;
        way = w[0];
      end
    end
    victim = toggle;
    wbPred = !hitPred && shValid[victim][idx] && shDirty[victim][idx];
    wbAddr = {shTag[victim][idx], idx, {`DC_OFFSET_W{1'b0}}};
    for (int k = 0; k < `DC_BEATS; k++) begin
      wbLine[k*`DC_XLEN +: `DC_XLEN] = expectedWord(wbAddr + addrT'(k * 8));
    end
    expData = expectedWord(addr);

    @(negedge clk);
    reqValid = 1'b1;
    reqWe = we;
    reqAddr = addr;
    reqWdata = wdata;
    reqWmask = mask;
    waited = 0;
    while (!reqReady) begin
      @(negedge clk);
      waited++;
      if (waited > WaitLimit) begin
        reportFailure("req_ready_o never rose for a new request");
      end
    end
    waitForResponse();

    if (hitPred) begin
      assert (rspCycles == 1) else reportMismatch("hit response cycles", rspCycles, 1);
    end
    assert (sawRd == !hitPred) else reportMismatch("rd_valid_o seen", sawRd, !hitPred);
    if (!hitPred) begin
      assert (seenRdAddr == {tag, idx, {`DC_OFFSET_W{1'b0}}})
        else reportMismatch("rd_addr_o", seenRdAddr, {tag, idx, {`DC_OFFSET_W{1'b0}}});
    end
    assert (sawWr == wbPred) else reportMismatch("wr_valid_o seen", sawWr, wbPred);
    if (wbPred) begin
      assert (wrFirst) else reportFailure("write-back did not come before the refill request");
      assert (seenWrAddr == wbAddr) else reportMismatch("wr_addr_o", seenWrAddr, wbAddr);
      assert (seenWrData == wbLine) else reportMismatch("wr_data_o", seenWrData, wbLine);
    end
    if (!we) begin
      assert (rspData == expData) else reportMismatch("rsp_rdata_o", rspData, expData);
    end

    if (!hitPred) begin
      shTag[victim][idx] = tag;
      shValid[victim][idx] = 1'b1;
      shDirty[victim][idx] = 1'b0;
      way = victim;
      toggle = ~toggle;
    end
    if (we) begin
      shDirty[way][idx] = 1'b1;
      written[{addr[`DC_ADDR_W-1:3], 3'b000}] = mergeBytes(expData, wdata, mask);
    end
  endtask

  task automatic checkResetValues();
    rst_n = 1'b0;
    repeat (3) begin
      @(negedge clk);
      checkIdleOutputs();
    end
    rst_n = 1'b1;
    @(negedge clk);
    checkIdleOutputs();
  endtask

  task automatic loadMissThenHit();
    issueAccess(1'b0, composeAddr(21'h01a2b, 6'd5, 2'd2), '0, '0);
    assert (sawRd) else reportFailure("load miss did not request a refill");
    issueAccess(1'b0, composeAddr(21'h01a2b, 6'd5, 2'd1), '0, '0);
    assert (!sawRd && rspCycles == 1) else reportFailure("second load in the line did not hit");
  endtask

  task automatic storeWithByteMask();
    addrT     a;
    wordT     oldWord;
    wordT     newWord;
    byteMaskT mask;
    a = composeAddr(21'h01a2b, 6'd5, 2'd3);
    oldWord = expectedWord(a);
    newWord = {$urandom, $urandom};
    mask = byteMaskT'($urandom);
    issueAccess(1'b1, a, newWord, mask);
    issueAccess(1'b0, a, '0, '0);
    assert (rspData == mergeBytes(oldWord, newWord, mask))
      else reportMismatch("rsp_rdata_o", rspData, mergeBytes(oldWord, newWord, mask));
  endtask

  task automatic evictDirtyLine();
    addrT first;
    wordT memWord;
    lineT expLine;
    first = composeAddr(21'h00111, 6'd9, 2'd0);
    issueAccess(1'b1, first, 64'hdead_beef_0123_4567, 8'hf0);
    issueAccess(1'b0, composeAddr(21'h00222, 6'd9, 2'd1), '0, '0);
    // victim line as it stands before it leaves the cache
    for (int k = 0; k < `DC_BEATS; k++) begin
      expLine[k*`DC_XLEN +: `DC_XLEN] = expectedWord(first + addrT'(k * 8));
    end
    issueAccess(1'b0, composeAddr(21'h00333, 6'd9, 2'd2), '0, '0);
    assert (sawWr) else reportFailure("dirty victim was not written back");
    // memory must now hold the merged line
    for (int k = 0; k < `DC_BEATS; k++) begin
      memWord = memModel.peekWord(first + addrT'(k * 8));
      assert (memWord == expLine[k*`DC_XLEN +: `DC_XLEN])
        else reportMismatch("memory image", memWord, expLine[k*`DC_XLEN +: `DC_XLEN]);
    end
  endtask

  task automatic holdUnderBackPressure();
    memDelay = 8'd12;
    issueAccess(1'b1, composeAddr(21'h00333, 6'd9, 2'd0), {$urandom, $urandom}, 8'h3c);
    issueAccess(1'b0, composeAddr(21'h00444, 6'd9, 2'd3), '0, '0);
    issueAccess(1'b0, composeAddr(21'h00555, 6'd9, 2'd1), '0, '0);
    assert (sawWr) else reportFailure("write-back under back-pressure did not happen");
    memDelay = 8'd3;
  endtask

  initial begin
    void'($urandom(32'hf506091b));
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqWe = 1'b0;
    reqAddr = '0;
    reqWdata = '0;
    reqWmask = '0;
    memDelay = 8'd3;
    toggle = 1'b0;
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < `DC_SETS; s++) begin
        shTag[w][s] = '0;
        shValid[w][s] = 1'b0;
        shDirty[w][s] = 1'b0;
      end
    end
    checkResetValues();
    loadMissThenHit();
    storeWithByteMask();
    evictDirtyLine();
    holdUnderBackPressure();
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* dcache2way.f */
+incdir+.
dcachePkg.sv
dcacheTagStore.sv
dcacheDataStore.sv
dcacheRefillBuf.sv
dcacheCtrl.sv
dcache2way.sv
tbDcacheMem.sv
tb_dcache2way.sv

/* Bender.yml */
package:
  name: dcache2way

export_include_dirs:
  - .

sources:
  - dcachePkg.sv
  - dcacheTagStore.sv
  - dcacheDataStore.sv
  - dcacheRefillBuf.sv
  - dcacheCtrl.sv
  - dcache2way.sv
  - target: test
    files:
      - tbDcacheMem.sv
      - tb_dcache2way.sv
